// ==== common/ddr3_test_pkg.sv ====
`default_nettype none

package ddr3_test_pkg;

	// controller address counts 32-bit DQ words: row 15 + bank 3 + col 10
	localparam int ADDR_W = 28;

	// one user beat is eight DQ words
	localparam int DATA_W = 256;
	localparam int LANES = 8;

	localparam int BURST_BEATS = 16;
	localparam logic [3:0] AXI_LEN = 4'(BURST_BEATS - 1);
	localparam int BURST_WORDS = BURST_BEATS * LANES;

	localparam logic [31:0] PATTERN_KEY = 32'h5a3c_96e1;

	typedef enum logic {
		OP_WRITE,
		OP_READ
	} test_op_e;

	// shared by the write and read burst masters
	typedef enum logic [1:0] {
		IDLE,
		ADDR,
		DATA,
		NEXT
	} burst_state_e;

	// lane k carries word (addr + k) xor key
	function automatic logic [DATA_W-1:0] pattern_beat(input logic [ADDR_W-1:0] addr);
		logic [DATA_W-1:0] beat;
		logic [ADDR_W-1:0] word;
		beat = '0;
		for (int k = 0; k < LANES; k++) begin
			word = addr + ADDR_W'(k);
			beat[k*32 +: 32] = 32'(word) ^ PATTERN_KEY;
		end
		return beat;
	endfunction

endpackage

`default_nettype wire

// ==== verilog/heartbeat.sv ====
`default_nettype none

module heartbeat #(
	parameter int unsigned HEARTBEAT_TH = 50_000_000
) (
	input  logic ddr3_core_clk,
	input  logic resetn,
	output logic heart_beat
);

	localparam int CNT_W = $clog2(HEARTBEAT_TH + 1);

	logic [CNT_W-1:0] cnt;
	logic             wrap;

	// period between toggles is HEARTBEAT_TH + 1
	assign wrap = (cnt == CNT_W'(HEARTBEAT_TH));

	always_ff @(posedge ddr3_core_clk or negedge resetn) begin
		if (!resetn) begin
			cnt        <= '0;
			heart_beat <= 1'b1;
		end else if (wrap) begin
			cnt        <= '0;
			heart_beat <= ~heart_beat;
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/test_cmd_ctrl.sv ====
`default_nettype none

module test_cmd_ctrl (
	input  logic                    ddr3_core_clk,
	input  logic                    resetn,
	input  logic                    cmd_req,
	input  ddr3_test_pkg::test_op_e cmd_op,
	output logic                    cmd_ack,
	output logic                    wr_start,
	output logic                    rd_start,
	input  logic                    wr_done,
	input  logic                    rd_done
);
	import ddr3_test_pkg::*;

	typedef enum logic [1:0] {
		WAIT_REQ,
		RUN,
		ACK,
		WAIT_DROP
	} cmd_state_e;

	cmd_state_e state;
	logic       req_q;
	test_op_e   op_q;
	logic       done_hit;

	// only the done of the running test counts
	assign done_hit = (op_q == OP_WRITE) ? wr_done : rd_done;

	always_ff @(posedge ddr3_core_clk or negedge resetn) begin
		if (!resetn) begin
			state    <= WAIT_REQ;
			req_q    <= 1'b0;
			op_q     <= OP_WRITE;
			cmd_ack  <= 1'b0;
			wr_start <= 1'b0;
			rd_start <= 1'b0;
		end else begin
			req_q    <= cmd_req;
			wr_start <= 1'b0;
			rd_start <= 1'b0;
			case (state)
				WAIT_REQ: begin
					if (req_q) begin
						op_q     <= cmd_op;
						wr_start <= (cmd_op == OP_WRITE);
						rd_start <= (cmd_op == OP_READ);
						state    <= RUN;
					end
				end
				RUN: begin
					if (done_hit) begin
						cmd_ack <= 1'b1;
						state   <= ACK;
					end
				end
				ACK: begin
					if (!req_q) begin
						cmd_ack <= 1'b0;
						state   <= WAIT_DROP;
					end
				end
				// turnaround before the next request
				WAIT_DROP: begin
					if (!req_q)
						state <= WAIT_REQ;
				end
				default: state <= WAIT_REQ;
			endcase
		end
	end

	// req was high on the edge that raised ack
	ast_ack_needs_req: assert property (@(posedge ddr3_core_clk) disable iff (!resetn)
		$rose(cmd_ack) |-> $past(cmd_req))
		else $error("cmd_ack rose without cmd_req");

endmodule

`default_nettype wire

// ==== axi_write/burst_writer.sv ====
`default_nettype none

module burst_writer #(
	parameter int MEM_SPACE_AW = 28
) (
	input  logic                               ddr3_core_clk,
	input  logic                               resetn,
	input  logic                               wr_start,
	output logic                               wr_done,
	output logic [ddr3_test_pkg::ADDR_W-1:0]   axi_awaddr,
	output logic [3:0]                         axi_awlen,
	output logic                               axi_awvalid,
	input  logic                               axi_awready,
	output logic [ddr3_test_pkg::DATA_W-1:0]   axi_wdata,
	input  logic                               axi_wready
);
	import ddr3_test_pkg::*;

	// start address of the final burst in the region
	localparam logic [ADDR_W-1:0] LAST_ADDR = ADDR_W'(2 ** MEM_SPACE_AW - BURST_WORDS);

	burst_state_e state;
	logic [3:0]   beat_cnt;

	assign axi_awlen = AXI_LEN;

	// memory pulls beats, so data is formed from the beat counter
	assign axi_wdata = pattern_beat(axi_awaddr + ADDR_W'(beat_cnt * LANES));

	always_ff @(posedge ddr3_core_clk or negedge resetn) begin
		if (!resetn) begin
			state       <= IDLE;
			axi_awaddr  <= '0;
			axi_awvalid <= 1'b0;
			beat_cnt    <= '0;
			wr_done     <= 1'b0;
		end else begin
			wr_done <= 1'b0;
			case (state)
				IDLE: begin
					if (wr_start) begin
						axi_awaddr  <= '0;
						axi_awvalid <= 1'b1;
						beat_cnt    <= '0;
						state       <= ADDR;
					end
				end
				ADDR: begin
					if (axi_awready) begin
						axi_awvalid <= 1'b0;
						state       <= DATA;
					end
				end
				DATA: begin
					if (axi_wready) begin
						beat_cnt <= beat_cnt + 4'd1;
						// next beat is the last of the burst
						if (beat_cnt == AXI_LEN - 4'd1)
							state <= NEXT;
					end
				end
				NEXT: begin
					if (axi_wready) begin
						beat_cnt <= '0;
						if (axi_awaddr == LAST_ADDR) begin
							wr_done <= 1'b1;
							state   <= IDLE;
						end else begin
							axi_awaddr  <= axi_awaddr + ADDR_W'(BURST_WORDS);
							axi_awvalid <= 1'b1;
							state       <= ADDR;
						end
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	ast_aw_hold: assert property (@(posedge ddr3_core_clk) disable iff (!resetn)
		axi_awvalid && !axi_awready |=> axi_awvalid && $stable(axi_awaddr))
		else $error("awvalid or awaddr changed before awready");

endmodule

`default_nettype wire

// ==== axi_read/burst_reader.sv ====
`default_nettype none

module burst_reader #(
	parameter int MEM_SPACE_AW = 28
) (
	input  logic                               ddr3_core_clk,
	input  logic                               resetn,
	input  logic                               rd_start,
	output logic                               rd_done,
	output logic [ddr3_test_pkg::ADDR_W-1:0]   axi_araddr,
	output logic [3:0]                         axi_arlen,
	output logic                               axi_arvalid,
	input  logic                               axi_arready,
	input  logic                               axi_rvalid,
	input  logic                               axi_rlast,
	output logic [ddr3_test_pkg::ADDR_W-1:0]   beat_addr
);
	import ddr3_test_pkg::*;

	localparam logic [ADDR_W-1:0] LAST_ADDR = ADDR_W'(2 ** MEM_SPACE_AW - BURST_WORDS);

	burst_state_e state;
	logic [3:0]   beat_cnt;

	assign axi_arlen = AXI_LEN;
	assign beat_addr = axi_araddr + ADDR_W'(beat_cnt * LANES);

	always_ff @(posedge ddr3_core_clk or negedge resetn) begin
		if (!resetn) begin
			state       <= IDLE;
			axi_araddr  <= '0;
			axi_arvalid <= 1'b0;
			beat_cnt    <= '0;
			rd_done     <= 1'b0;
		end else begin
			rd_done <= 1'b0;
			case (state)
				IDLE: if (rd_start) begin
					axi_araddr  <= '0;
					axi_arvalid <= 1'b1;
					beat_cnt    <= '0;
					state       <= ADDR;
				end
				ADDR: if (axi_arready) begin
					axi_arvalid <= 1'b0;
					state       <= DATA;
				end
				DATA: if (axi_rvalid) begin
					beat_cnt <= beat_cnt + 4'd1;
					if (beat_cnt == AXI_LEN - 4'd1)
						state <= NEXT;
				end
				// waiting on the final beat
				NEXT: if (axi_rvalid) begin
					beat_cnt <= '0;
					if (axi_araddr == LAST_ADDR) begin
						rd_done <= 1'b1;
						state   <= IDLE;
					end else begin
						axi_araddr  <= axi_araddr + ADDR_W'(BURST_WORDS);
						axi_arvalid <= 1'b1;
						state       <= ADDR;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	ast_rlast_16th: assert property (@(posedge ddr3_core_clk) disable iff (!resetn)
		axi_rvalid && (state == DATA || state == NEXT) |-> (axi_rlast == (state == NEXT)))
		else $error("rlast not aligned with the 16th beat");

endmodule

`default_nettype wire

// ==== axi_read/read_checker.sv ====
`default_nettype none

module read_checker (
	input  logic                               ddr3_core_clk,
	input  logic                               resetn,
	input  logic                               rd_start,
	input  logic                               axi_rvalid,
	input  logic [ddr3_test_pkg::DATA_W-1:0]   axi_rdata,
	input  logic [ddr3_test_pkg::ADDR_W-1:0]   beat_addr,
	output logic                               err_flag
);
	import ddr3_test_pkg::*;

	logic [DATA_W-1:0] expect_beat;
	logic [LANES-1:0]  lane_bad;
	logic              beat_bad;

	assign expect_beat = pattern_beat(beat_addr);

	// per-lane compare, handy when probing a failing word
	always_comb begin
		for (int k = 0; k < LANES; k++) begin
			lane_bad[k] = (axi_rdata[k*32 +: 32] != expect_beat[k*32 +: 32]);
		end
	end

	assign beat_bad = axi_rvalid && (|lane_bad);

	//********************************************************************
	// sticky error, cleared at each read test start
	//********************************************************************
	always_ff @(posedge ddr3_core_clk or negedge resetn) begin
		if (!resetn) begin
			err_flag <= 1'b0;
		end else if (rd_start) begin
			err_flag <= 1'b0;
		end else if (beat_bad) begin
			err_flag <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/ddr3_test_top.sv ====
`default_nettype none

module ddr3_test_top #(
	parameter int          MEM_SPACE_AW = 28,
	parameter int unsigned HEARTBEAT_TH = 50_000_000
) (
	input  logic                               ddr3_core_clk,
	input  logic                               resetn,
	input  logic                               cmd_req,
	input  ddr3_test_pkg::test_op_e            cmd_op,
	output logic                               cmd_ack,
	output logic [ddr3_test_pkg::ADDR_W-1:0]   axi_awaddr,
	output logic [3:0]                         axi_awlen,
	output logic                               axi_awvalid,
	input  logic                               axi_awready,
	output logic [ddr3_test_pkg::DATA_W-1:0]   axi_wdata,
	input  logic                               axi_wready,
	output logic [ddr3_test_pkg::ADDR_W-1:0]   axi_araddr,
	output logic [3:0]                         axi_arlen,
	output logic                               axi_arvalid,
	input  logic                               axi_arready,
	input  logic [ddr3_test_pkg::DATA_W-1:0]   axi_rdata,
	input  logic                               axi_rlast,
	input  logic                               axi_rvalid,
	output logic                               err_flag,
	output logic                               heart_beat
);
	import ddr3_test_pkg::*;

	logic              wr_start;
	logic              wr_done;
	logic              rd_start;
	logic              rd_done;
	logic [ADDR_W-1:0] beat_addr;

	//********************************************************************
	// command handshake
	//********************************************************************
	test_cmd_ctrl u_test_cmd_ctrl (
		.ddr3_core_clk (ddr3_core_clk),
		.resetn        (resetn),
		.cmd_req       (cmd_req),
		.cmd_op        (cmd_op),
		.cmd_ack       (cmd_ack),
		.wr_start      (wr_start),
		.rd_start      (rd_start),
		.wr_done       (wr_done),
		.rd_done       (rd_done)
	);

	//********************************************************************
	// write and read masters
	//********************************************************************
	burst_writer #(
		.MEM_SPACE_AW (MEM_SPACE_AW)
	) u_burst_writer (
		.ddr3_core_clk (ddr3_core_clk),
		.resetn        (resetn),
		.wr_start      (wr_start),
		.wr_done       (wr_done),
		.axi_awaddr    (axi_awaddr),
		.axi_awlen     (axi_awlen),
		.axi_awvalid   (axi_awvalid),
		.axi_awready   (axi_awready),
		.axi_wdata     (axi_wdata),
		.axi_wready    (axi_wready)
	);

	burst_reader #(
		.MEM_SPACE_AW (MEM_SPACE_AW)
	) u_burst_reader (
		.ddr3_core_clk (ddr3_core_clk),
		.resetn        (resetn),
		.rd_start      (rd_start),
		.rd_done       (rd_done),
		.axi_araddr    (axi_araddr),
		.axi_arlen     (axi_arlen),
		.axi_arvalid   (axi_arvalid),
		.axi_arready   (axi_arready),
		.axi_rvalid    (axi_rvalid),
		.axi_rlast     (axi_rlast),
		.beat_addr     (beat_addr)
	);

	read_checker u_read_checker (
		.ddr3_core_clk (ddr3_core_clk),
		.resetn        (resetn),
		.rd_start      (rd_start),
		.axi_rvalid    (axi_rvalid),
		.axi_rdata     (axi_rdata),
		.beat_addr     (beat_addr),
		.err_flag      (err_flag)
	);

	heartbeat #(
		.HEARTBEAT_TH (HEARTBEAT_TH)
	) u_heartbeat (
		.ddr3_core_clk (ddr3_core_clk),
		.resetn        (resetn),
		.heart_beat    (heart_beat)
	);

endmodule

`default_nettype wire

// ==== tests/axi_mem_model.sv ====
`default_nettype none

module axi_mem_model #(
	parameter int MEM_AW = 10
) (
	input  logic                               ddr3_core_clk,
	input  logic                               resetn,
	input  logic [ddr3_test_pkg::ADDR_W-1:0]   axi_awaddr,
	input  logic                               axi_awvalid,
	output logic                               axi_awready,
	input  logic [ddr3_test_pkg::DATA_W-1:0]   axi_wdata,
	output logic                               axi_wready,
	input  logic [ddr3_test_pkg::ADDR_W-1:0]   axi_araddr,
	input  logic                               axi_arvalid,
	output logic                               axi_arready,
	output logic [ddr3_test_pkg::DATA_W-1:0]   axi_rdata,
	output logic                               axi_rlast,
	output logic                               axi_rvalid,
	input  logic                               fault_en,
	input  logic [ddr3_test_pkg::ADDR_W-1:0]   fault_addr,
	input  logic [4:0]                         fault_bit
);
	import ddr3_test_pkg::*;

	localparam int WORDS = 2 ** MEM_AW;

	logic [31:0]       mem [0:WORDS-1];
	logic [31:0]       rnd;
	logic [ADDR_W-1:0] wr_base;
	logic [ADDR_W-1:0] rd_base;
	logic [3:0]        wr_beat;
	logic [3:0]        rd_beat;
	logic              wr_active;
	logic              rd_active;
	logic [DATA_W-1:0] beat;
	logic [31:0]       word;
	int                idx;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x;
		y = y ^ (y << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	initial begin
		rnd = 32'hd3a2;
		axi_awready = 1'b0;
		axi_wready = 1'b0;
		axi_arready = 1'b0;
		axi_rvalid = 1'b0;
		axi_rlast = 1'b0;
		axi_rdata = '0;
		// scrambled fill, so unwritten words never look like the pattern
		for (int i = 0; i < WORDS; i++) begin
			mem[i] = (32'(i) * 32'h9e37_79b9) ^ 32'hffff_0000;
		end
	end

	//**********************************************************************
	// burst bookkeeping, sampled on the rising edge
	//**********************************************************************
	always @(posedge ddr3_core_clk or negedge resetn) begin
		if (!resetn) begin
			wr_active <= 1'b0;
			rd_active <= 1'b0;
			wr_beat <= '0;
			rd_beat <= '0;
			wr_base <= '0;
			rd_base <= '0;
		end else begin
			if (axi_awvalid && axi_awready) begin
				wr_base <= axi_awaddr;
				wr_beat <= '0;
				wr_active <= 1'b1;
			end
			if (wr_active && axi_wready) begin
				for (int k = 0; k < LANES; k++) begin
					mem[(int'(wr_base) + int'(wr_beat) * LANES + k) % WORDS] <=
						axi_wdata[k*32 +: 32];
				end
				wr_beat <= wr_beat + 4'd1;
				if (wr_beat == 4'd15)
					wr_active <= 1'b0;
			end
			if (axi_arvalid && axi_arready) begin
				rd_base <= axi_araddr;
				rd_beat <= '0;
				rd_active <= 1'b1;
			end
			if (rd_active && axi_rvalid) begin
				rd_beat <= rd_beat + 4'd1;
				if (rd_beat == 4'd15)
					rd_active <= 1'b0;
			end
		end
	end

	// ready and valid gaps, driven on the falling edge
	always @(negedge ddr3_core_clk) begin
		rnd = xorshift32(rnd);
		beat = '0;
		for (int k = 0; k < LANES; k++) begin
			idx = int'(rd_base) + int'(rd_beat) * LANES + k;
			word = mem[idx % WORDS];
			if (fault_en && idx == int'(fault_addr))
				word[fault_bit] = ~word[fault_bit];
			beat[k*32 +: 32] = word;
		end
		if (!resetn) begin
			axi_awready <= 1'b0;
			axi_wready <= 1'b0;
			axi_arready <= 1'b0;
			axi_rvalid <= 1'b0;
			axi_rlast <= 1'b0;
		end else begin
			axi_awready <= !wr_active && (rnd[1:0] != 2'd0);
			axi_wready <= wr_active && (rnd[3:2] != 2'd0);
			axi_arready <= !rd_active && (rnd[5:4] != 2'd0);
			axi_rvalid <= rd_active && (rnd[7:6] != 2'd0);
			axi_rlast <= rd_active && (rd_beat == 4'd15);
			axi_rdata <= beat;
		end
	end

endmodule

`default_nettype wire

// ==== tests/tb_ddr3_test.sv ====
`default_nettype none

module tb_ddr3_test;
	import ddr3_test_pkg::*;

	localparam int MEM_AW = 10;
	localparam int BURSTS = (2 ** MEM_AW) / 128;
	localparam int MAX_CMDS = 32;
	localparam logic [31:0] NO_FAULT = 32'hffff_ffff;

	logic              ddr3_core_clk = 1'b0;
	logic              resetn;
	logic              cmd_req;
	test_op_e          cmd_op;
	logic              cmd_ack;
	logic [ADDR_W-1:0] axi_awaddr;
	logic [3:0]        axi_awlen;
	logic              axi_awvalid;
	logic              axi_awready;
	logic [DATA_W-1:0] axi_wdata;
	logic              axi_wready;
	logic [ADDR_W-1:0] axi_araddr;
	logic [3:0]        axi_arlen;
	logic              axi_arvalid;
	logic              axi_arready;
	logic [DATA_W-1:0] axi_rdata;
	logic              axi_rlast;
	logic              axi_rvalid;
	logic              err_flag;
	logic              heart_beat;
	logic              fault_en;
	logic [ADDR_W-1:0] fault_addr;
	logic [4:0]        fault_bit;

	logic [31:0] stim [0:4*MAX_CMDS-1];
	int          n_cmds;
	int          cycle_cnt = 0;
	int          cycle_limit = 2000;
	int          aw_count;
	int          ar_count;
	int          aw_expect;
	int          ar_expect;

	always #2 ddr3_core_clk = ~ddr3_core_clk;

	ddr3_test_top #(
		.MEM_SPACE_AW (MEM_AW),
		.HEARTBEAT_TH (50)
	) DUT (
		.ddr3_core_clk (ddr3_core_clk),
		.resetn        (resetn),
		.cmd_req       (cmd_req),
		.cmd_op        (cmd_op),
		.cmd_ack       (cmd_ack),
		.axi_awaddr    (axi_awaddr),
		.axi_awlen     (axi_awlen),
		.axi_awvalid   (axi_awvalid),
		.axi_awready   (axi_awready),
		.axi_wdata     (axi_wdata),
		.axi_wready    (axi_wready),
		.axi_araddr    (axi_araddr),
		.axi_arlen     (axi_arlen),
		.axi_arvalid   (axi_arvalid),
		.axi_arready   (axi_arready),
		.axi_rdata     (axi_rdata),
		.axi_rlast     (axi_rlast),
		.axi_rvalid    (axi_rvalid),
		.err_flag      (err_flag),
		.heart_beat    (heart_beat)
	);

	axi_mem_model #(
		.MEM_AW (MEM_AW)
	) mem_model (
		.ddr3_core_clk (ddr3_core_clk),
		.resetn        (resetn),
		.axi_awaddr    (axi_awaddr),
		.axi_awvalid   (axi_awvalid),
		.axi_awready   (axi_awready),
		.axi_wdata     (axi_wdata),
		.axi_wready    (axi_wready),
		.axi_araddr    (axi_araddr),
		.axi_arvalid   (axi_arvalid),
		.axi_arready   (axi_arready),
		.axi_rdata     (axi_rdata),
		.axi_rlast     (axi_rlast),
		.axi_rvalid    (axi_rvalid),
		.fault_en      (fault_en),
		.fault_addr    (fault_addr),
		.fault_bit     (fault_bit)
	);

	task automatic check_value(input string name, input logic [63:0] expected,
			input logic [63:0] actual);
		if (expected !== actual) begin
			$display("[ERROR] %s: expected %0h, actual %0h", name, expected, actual);
			$display("Test failed");
			$fatal(1);
		end
	endtask

	//**********************************************************************
	// address channel monitor
	//**********************************************************************
	always @(posedge ddr3_core_clk) begin
		if (resetn && axi_awvalid && axi_awready) begin
			check_value("awlen", 64'd15, 64'(axi_awlen));
			check_value("awaddr", 64'(aw_expect), 64'(axi_awaddr));
			aw_expect += 128;
			aw_count++;
		end
		if (resetn && axi_arvalid && axi_arready) begin
			check_value("arlen", 64'd15, 64'(axi_arlen));
			check_value("araddr", 64'(ar_expect), 64'(axi_araddr));
			ar_expect += 128;
			ar_count++;
		end
	end

	always @(posedge ddr3_core_clk) begin
		cycle_cnt++;
		if (cycle_cnt > cycle_limit) begin
			$display("timeout: the cmd_req/cmd_ack handshake hung after %0d cycles",
				cycle_cnt);
			$display("Test failed");
			$fatal(1);
		end
	end

	// negedge count between two heart_beat edges
	task automatic measure_toggle(output int n);
		logic prev;
		n = 0;
		prev = heart_beat;
		do begin
			@(negedge ddr3_core_clk);
			n++;
		end while (heart_beat == prev);
	endtask

	task automatic run_command(input int idx);
		test_op_e    op;
		logic [31:0] faddr;
		logic        exp_err;
		string       tag;
		op = test_op_e'(stim[4*idx][0]);
		faddr = stim[4*idx+1];
		exp_err = stim[4*idx+3][0];
		tag = $sformatf("cmd %0d", idx);
		@(negedge ddr3_core_clk);
		fault_en = (faddr != NO_FAULT);
		fault_addr = faddr[ADDR_W-1:0];
		fault_bit = stim[4*idx+2][4:0];
		aw_count = 0;
		ar_count = 0;
		aw_expect = 0;
		ar_expect = 0;
		cmd_op = op;
		cmd_req = 1'b1;
		while (!cmd_ack)
			@(negedge ddr3_core_clk);
		check_value($sformatf("%s err_flag", tag), 64'(exp_err), 64'(err_flag));
		if (op == OP_WRITE) begin
			check_value($sformatf("%s aw bursts", tag), 64'(BURSTS), 64'(aw_count));
			check_value($sformatf("%s ar bursts", tag), 64'd0, 64'(ar_count));
			for (int w = 0; w < 2 ** MEM_AW; w++) begin
				check_value($sformatf("%s mem[%0d]", tag, w),
					64'(32'(w) ^ PATTERN_KEY), 64'(mem_model.mem[w]));
			end
		end else begin
			check_value($sformatf("%s ar bursts", tag), 64'(BURSTS), 64'(ar_count));
			check_value($sformatf("%s aw bursts", tag), 64'd0, 64'(aw_count));
		end
		cmd_req = 1'b0;
		while (cmd_ack)
			@(negedge ddr3_core_clk);
		fault_en = 1'b0;
	endtask

	initial begin
		int n;
		resetn = 1'b0;
		cmd_req = 1'b0;
		cmd_op = OP_WRITE;
		fault_en = 1'b0;
		fault_addr = '0;
		fault_bit = '0;
		for (int i = 0; i < 4 * MAX_CMDS; i++) begin
			stim[i] = NO_FAULT;
		end
		$readmemh("tests/ddr3_test_stim.txt", stim);
		n_cmds = 0;
		while (n_cmds < MAX_CMDS && stim[4*n_cmds] != NO_FAULT)
			n_cmds++;
		cycle_limit = n_cmds * BURSTS * 16 * 4 + 2000;

		repeat (10) @(negedge ddr3_core_clk);
		resetn = 1'b1;
		check_value("reset cmd_ack", 64'd0, 64'(cmd_ack));
		check_value("reset awvalid", 64'd0, 64'(axi_awvalid));
		check_value("reset arvalid", 64'd0, 64'(axi_arvalid));
		check_value("reset err_flag", 64'd0, 64'(err_flag));
		check_value("reset heart_beat", 64'd1, 64'(heart_beat));

		// first edge only aligns
		measure_toggle(n);
		measure_toggle(n);
		check_value("heartbeat period", 64'd51, 64'(n));
		measure_toggle(n);
		check_value("heartbeat period", 64'd51, 64'(n));

		for (int c = 0; c < n_cmds; c++) begin
			run_command(c);
		end

		$display("Test passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tests/ddr3_test_stim.txt ====
// opcode (0 write, 1 read), fault word address (ffffffff none), fault bit, expected err_flag
// faults flip one bit of one word on reads only
0 ffffffff 00 0
1 ffffffff 00 0
1 00000000 00 1
1 ffffffff 00 0
1 0000007f 1f 1
0 ffffffff 00 1
1 ffffffff 00 0
1 00000080 10 1
1 000003ff 07 1
1 ffffffff 00 0
1 00000155 0a 1
1 000002a7 03 1
0 ffffffff 00 1
1 ffffffff 00 0
1 00000200 00 1
1 ffffffff 00 0
0 ffffffff 00 0
1 ffffffff 00 0

// ==== src.f ====
common/ddr3_test_pkg.sv
verilog/heartbeat.sv
verilog/test_cmd_ctrl.sv
axi_write/burst_writer.sv
axi_read/burst_reader.sv
axi_read/read_checker.sv
verilog/ddr3_test_top.sv
tests/axi_mem_model.sv
tests/tb_ddr3_test.sv

// ==== Bender.yml ====
package:
  name: ddr3_test

sources:
  - common/ddr3_test_pkg.sv
  - verilog/heartbeat.sv
  - verilog/test_cmd_ctrl.sv
  - axi_write/burst_writer.sv
  - axi_read/burst_reader.sv
  - axi_read/read_checker.sv
  - verilog/ddr3_test_top.sv
  - target: test
    files:
      - tests/axi_mem_model.sv
      - tests/tb_ddr3_test.sv
